// File: all.f
hdl/mem_pkg.sv
hdl/dual_port_sram.sv
hdl/fetch_port.sv
hdl/data_port.sv
hdl/mem_subsystem.sv
test/mem_subsystem_props.sv
test/mem_subsystem_tb.sv

// File: Makefile
# Verilator build and run of the memory backend testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := mem_subsystem_tb
FILELIST  := all.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# The simulation binary exits nonzero when the run fails
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: test/mem_subsystem_tb.sv
// Memory backend testbench with clock, reset, LFSR stimulus, reference model and checks
`timescale 1ns/100ps

module mem_subsystem_tb
    import mem_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int WINDOW_WORDS = 64;
    localparam int RANDOM_CYCLES = 2000;
    // About 2200 cycles of reset, fill, directed cases and random mix
    localparam int TIMEOUT_CYCLES = 6000;
    // Upper address bits of the 64-word test window
    localparam logic [5:0] WINDOW_TOP = 6'h29;
    localparam logic [15:0] LFSR_SEED = 16'd79;

    logic       clk;
    logic       rst_n;
    logic       fetch_req_valid;
    fetch_req_t fetch_req;
    logic       fetch_rsp_valid;
    fetch_rsp_t fetch_rsp;
    logic       data_req_valid;
    data_req_t  data_req;
    logic       data_rsp_valid;
    data_rsp_t  data_rsp;

    // Byte model of the window indexed by the low byte address
    logic [7:0]  ref_mem [256];
    fetch_rsp_t  fetch_q [$];
    data_rsp_t   data_q [$];
    logic [15:0] lfsr_state;
    int          cycles = 0;

    mem_subsystem u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req       (fetch_req),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .data_req_valid  (data_req_valid),
        .data_req        (data_req),
        .data_rsp_valid  (data_rsp_valid),
        .data_rsp        (data_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    // Cycle limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_run($sformatf("Timeout: run did not finish within %0d cycles", cycles));
        end
    end

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // n fresh bits with one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic misaligned_access(input mem_size_e size, input logic [1:0] off);
        case (size)
            size_byte: return 1'b0;
            size_half: return off[0];
            default:   return off != 2'b00;
        endcase
    endfunction

    function automatic logic [31:0] model_word(input logic [5:0] word);
        return {ref_mem[{word, 2'd3}], ref_mem[{word, 2'd2}],
                ref_mem[{word, 2'd1}], ref_mem[{word, 2'd0}]};
    endfunction

    // Expected fetch response holds the old contents of the word
    function automatic fetch_rsp_t expect_fetch(input fetch_req_t r);
        fetch_rsp_t e;
        e.err  = r.addr[1:0] != 2'b00;
        e.data = e.err ? 32'd0 : model_word(r.addr[7:2]);
        return e;
    endfunction

    // Expected data response by the load, store and alignment rules
    function automatic data_rsp_t expect_data(input data_req_t r);
        data_rsp_t  e;
        logic [7:0] a;
        logic [7:0] b;
        logic [15:0] h;
        a = r.addr[7:0];
        b = ref_mem[a];
        h = {ref_mem[a + 8'd1], ref_mem[a]};
        e.err  = misaligned_access(r.size, a[1:0]);
        e.data = 32'd0;
        if (!e.err && !r.write) begin
            case (r.size)
                size_byte: e.data = r.is_unsigned ? {24'd0, b} : {{24{b[7]}}, b};
                size_half: e.data = r.is_unsigned ? {16'd0, h} : {{16{h[15]}}, h};
                default:   e.data = model_word(a[7:2]);
            endcase
        end
        return e;
    endfunction

    // Aligned stores change only their own bytes
    task automatic update_model(input data_req_t r);
        logic [7:0] a;
        a = r.addr[7:0];
        if (r.write && !misaligned_access(r.size, a[1:0])) begin
            ref_mem[a] = r.wdata[7:0];
            if (r.size != size_byte) begin
                ref_mem[a + 8'd1] = r.wdata[15:8];
            end
            if (r.size == size_word) begin
                ref_mem[a + 8'd2] = r.wdata[23:16];
                ref_mem[a + 8'd3] = r.wdata[31:24];
            end
        end
    endtask

    function automatic fetch_req_t fetch_at(input logic [5:0] word, input logic [1:0] off);
        fetch_req_t f;
        f.addr = {WINDOW_TOP, word, off};
        return f;
    endfunction

    function automatic data_req_t data_at(input logic [5:0] word, input logic [1:0] off,
                                          input logic write, input mem_size_e size,
                                          input logic uns, input logic [31:0] wdata);
        data_req_t d;
        d.addr        = {WINDOW_TOP, word, off};
        d.write       = write;
        d.size        = size;
        d.is_unsigned = uns;
        d.wdata       = wdata;
        return d;
    endfunction

    // One cycle of requests with expectations taken before the store lands
    task automatic issue(input logic fv, input fetch_req_t f, input logic dv, input data_req_t d);
        fetch_req_valid = fv;
        fetch_req       = f;
        data_req_valid  = dv;
        data_req        = d;
        if (fv) begin
            fetch_q.push_back(expect_fetch(f));
        end
        if (dv) begin
            data_q.push_back(expect_data(d));
            update_model(d);
        end
        @(posedge clk);
        #0.5;
    endtask

    task automatic load_word(input logic [5:0] word);
        issue(1'b0, '0, 1'b1, data_at(word, 2'd0, 1'b0, size_word, 1'b0, 32'd0));
    endtask

    // Responses checked at the falling edge where outputs are stable
    always @(negedge clk) begin
        fetch_rsp_t fe;
        data_rsp_t  de;
        if (rst_n && fetch_rsp_valid) begin
            assert (fetch_q.size() != 0)
                else stop_run("A fetch response arrived while no fetch was pending");
            fe = fetch_q.pop_front();
            assert (fetch_rsp.err == fe.err)
                else stop_run($sformatf("Fail at %0t: fetch err got %b expected %b",
                                        $time, fetch_rsp.err, fe.err));
            assert (fetch_rsp.data == fe.data)
                else stop_run($sformatf("Fail at %0t: fetch data got %h expected %h",
                                        $time, fetch_rsp.data, fe.data));
        end
        if (rst_n && data_rsp_valid) begin
            assert (data_q.size() != 0)
                else stop_run("A data response arrived while no load or store was pending");
            de = data_q.pop_front();
            assert (data_rsp.err == de.err)
                else stop_run($sformatf("Fail at %0t: data err got %b expected %b",
                                        $time, data_rsp.err, de.err));
            assert (data_rsp.data == de.data)
                else stop_run($sformatf("Fail at %0t: data value got %h expected %h",
                                        $time, data_rsp.data, de.data));
        end
    end

    initial begin
        logic        fv;
        logic        dv;
        logic [1:0]  foff;
        logic [1:0]  sz;
        logic [5:0]  word;
        logic [1:0]  off;
        logic        wr;
        logic        uns;
        lfsr_state      = LFSR_SEED;
        rst_n           = 1'b0;
        fetch_req_valid = 1'b0;
        fetch_req       = '0;
        data_req_valid  = 1'b0;
        data_req        = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        @(posedge clk);
        #0.5;

        // Fill with word stores and then fetch and load every word together
        for (int w = 0; w < WINDOW_WORDS; w++) begin
            issue(1'b0, '0, 1'b1, data_at(6'(w), 2'd0, 1'b1, size_word, 1'b0, take_bits(32)));
        end
        for (int w = 0; w < WINDOW_WORDS; w++) begin
            issue(1'b1, fetch_at(6'(w), 2'd0), 1'b1,
                  data_at(6'(w), 2'd0, 1'b0, size_word, 1'b0, 32'd0));
        end

        // Byte and halfword stores at every legal offset with a word read after each
        for (int o = 0; o < 4; o++) begin
            issue(1'b0, '0, 1'b1, data_at(6'd1, 2'(o), 1'b1, size_byte, 1'b0, take_bits(32)));
            load_word(6'd1);
        end
        for (int o = 0; o < 4; o += 2) begin
            issue(1'b0, '0, 1'b1, data_at(6'd2, 2'(o), 1'b1, size_half, 1'b0, take_bits(32)));
            load_word(6'd2);
        end

        // Sign and zero extension on lanes with top bit set and clear
        issue(1'b0, '0, 1'b1, data_at(6'd3, 2'd0, 1'b1, size_word, 1'b0, 32'h8a7f_f005));
        issue(1'b0, '0, 1'b1, data_at(6'd4, 2'd0, 1'b1, size_word, 1'b0, 32'h7f12_1234));
        for (int w = 3; w < 5; w++) begin
            for (int u = 0; u < 2; u++) begin
                for (int o = 0; o < 4; o++) begin
                    issue(1'b0, '0, 1'b1,
                          data_at(6'(w), 2'(o), 1'b0, size_byte, 1'(u), 32'd0));
                end
                for (int o = 0; o < 4; o += 2) begin
                    issue(1'b0, '0, 1'b1,
                          data_at(6'(w), 2'(o), 1'b0, size_half, 1'(u), 32'd0));
                end
            end
        end

        // Misaligned stores, loads and fetches on word 5
        for (int o = 1; o < 4; o++) begin
            if (o[0]) begin
                issue(1'b0, '0, 1'b1, data_at(6'd5, 2'(o), 1'b1, size_half, 1'b0, 32'hffff_ffff));
                issue(1'b0, '0, 1'b1, data_at(6'd5, 2'(o), 1'b0, size_half, 1'b0, 32'd0));
            end
            issue(1'b0, '0, 1'b1, data_at(6'd5, 2'(o), 1'b1, size_word, 1'b0, 32'hffff_ffff));
            issue(1'b1, fetch_at(6'd5, 2'(o)), 1'b1,
                  data_at(6'd5, 2'(o), 1'b0, size_word, 1'b0, 32'd0));
        end
        issue(1'b1, fetch_at(6'd5, 2'd0), 1'b0, '0);
        load_word(6'd5);

        // Fetch and store of one word in the same cycle
        issue(1'b1, fetch_at(6'd6, 2'd0), 1'b1,
              data_at(6'd6, 2'd0, 1'b1, size_word, 1'b0, 32'h1357_9bdf));
        issue(1'b1, fetch_at(6'd6, 2'd0), 1'b1,
              data_at(6'd6, 2'd0, 1'b0, size_word, 1'b0, 32'd0));

        // Random mix with a random fetch offset about one time in eight
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            fv = 2'(take_bits(2)) != 2'd0;
            dv = 2'(take_bits(2)) != 2'd0;
            foff = 2'd0;
            if (3'(take_bits(3)) == 3'd0) begin
                foff = 2'(take_bits(2));
            end
            sz = 2'(take_bits(2));
            if (sz == 2'd3) begin
                sz = 2'd2;
            end
            word = 6'(take_bits(6));
            off  = 2'(take_bits(2));
            wr   = 1'(take_bits(1));
            uns  = 1'(take_bits(1));
            issue(fv, fetch_at(6'(take_bits(6)), foff), dv,
                  data_at(word, off, wr, mem_size_e'(sz), uns, take_bits(32)));
        end

        // Drain the last responses
        repeat (3) begin
            issue(1'b0, '0, 1'b0, '0);
        end
        if (fetch_q.size() == 0 && data_q.size() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            stop_run("Some requests never received a response");
        end
    end

endmodule

// File: test/mem_subsystem_props.sv
// Concurrent handshake and write-enable assertions bound to the memory backend top level
`timescale 1ns/100ps

module mem_subsystem_props
    import mem_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       fetch_req_valid,
    input logic       fetch_rsp_valid,
    input logic       data_req_valid,
    input data_req_t  data_req,
    input logic       data_rsp_valid,
    // SRAM write enables with index 0 for fetch
    input logic [1:0] sram_we
);

    logic data_misaligned;

    // Halfwords need an even offset, words a zero one
    always_comb begin
        case (data_req.size)
            size_byte: data_misaligned = 1'b0;
            size_half: data_misaligned = data_req.addr[0];
            size_word: data_misaligned = data_req.addr[1:0] != 2'b00;
            default:   data_misaligned = 1'b1;
        endcase
    end

    // Every request answered on the next edge
    fetch_rsp_follows: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req_valid |=> fetch_rsp_valid)
        else $error("fetch request not answered one cycle later");

    data_rsp_follows: assert property (@(posedge clk) disable iff (!rst_n)
        data_req_valid |=> data_rsp_valid)
        else $error("data request not answered one cycle later");

    // No response without a request the cycle before
    fetch_rsp_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        !fetch_req_valid |=> !fetch_rsp_valid)
        else $error("fetch response with no request");

    data_rsp_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        !data_req_valid |=> !data_rsp_valid)
        else $error("data response with no request");

    // Port 1 writes only for aligned stores
    data_we_legal: assert property (@(posedge clk) disable iff (!rst_n)
        sram_we[1] |-> (data_req_valid && data_req.write && !data_misaligned))
        else $error("SRAM write on a load or misaligned request");

    // Fetch side is read only
    fetch_we_low: assert property (@(posedge clk) disable iff (!rst_n)
        !sram_we[0])
        else $error("SRAM write on the fetch port");

endmodule

bind mem_subsystem mem_subsystem_props u_props (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_req_valid (fetch_req_valid),
    .fetch_rsp_valid (fetch_rsp_valid),
    .data_req_valid  (data_req_valid),
    .data_req        (data_req),
    .data_rsp_valid  (data_rsp_valid),
    .sram_we         (sram_we)
);

// File: hdl/mem_subsystem.sv
// Memory backend top level with fetch adapter, load/store adapter and shared dual-port SRAM
`timescale 1ns/100ps

module mem_subsystem
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // Instruction fetch
    input  logic       fetch_req_valid,
    input  fetch_req_t fetch_req,
    output logic       fetch_rsp_valid,
    output fetch_rsp_t fetch_rsp,
    // Loads and stores
    input  logic       data_req_valid,
    input  data_req_t  data_req,
    output logic       data_rsp_valid,
    output data_rsp_t  data_rsp
);

    // SRAM buses with index 0 for fetch and index 1 for data
    logic [1:0][WORD_ADDR_WIDTH-1:0] sram_addr;
    logic [1:0]                      sram_we;
    logic [1:0][WMASK_WIDTH-1:0]     sram_wmask;
    logic [1:0][DATA_WIDTH-1:0]      sram_wdata;
    logic [1:0][DATA_WIDTH-1:0]      sram_rdata;

    // Fetch side only reads
    assign sram_we[0]    = 1'b0;
    assign sram_wmask[0] = '0;
    assign sram_wdata[0] = '0;

    fetch_port u_fetch_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (fetch_req_valid),
        .req        (fetch_req),
        .sram_addr  (sram_addr[0]),
        .sram_rdata (sram_rdata[0]),
        .rsp_valid  (fetch_rsp_valid),
        .rsp        (fetch_rsp)
    );

    data_port u_data_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (data_req_valid),
        .req        (data_req),
        .sram_addr  (sram_addr[1]),
        .sram_we    (sram_we[1]),
        .sram_wmask (sram_wmask[1]),
        .sram_wdata (sram_wdata[1]),
        .sram_rdata (sram_rdata[1]),
        .rsp_valid  (data_rsp_valid),
        .rsp        (data_rsp)
    );

    dual_port_sram #(
        .DEPTH      (MEM_WORDS),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_sram (
        .clk   (clk),
        .addr  (sram_addr),
        .we    (sram_we),
        .wmask (sram_wmask),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

endmodule

// File: hdl/data_port.sv
// Load/store adapter with alignment check, lane placement, write mask and load extension
`timescale 1ns/100ps

module data_port
    import mem_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    // Request side from the core
    input  logic                       req_valid,
    input  data_req_t                  req,
    // SRAM port 1
    output logic [WORD_ADDR_WIDTH-1:0] sram_addr,
    output logic                       sram_we,
    output logic [WMASK_WIDTH-1:0]     sram_wmask,
    output logic [DATA_WIDTH-1:0]      sram_wdata,
    input  logic [DATA_WIDTH-1:0]      sram_rdata,
    // Response side one cycle after the request
    output logic                       rsp_valid,
    output data_rsp_t                  rsp
);

    logic [1:0]            offset;
    logic                  misaligned;

    // Response stage registers
    logic                  err_q;
    logic                  load_q;
    logic [1:0]            offset_q;
    mem_size_e             size_q;
    logic                  unsigned_q;

    // Load path
    logic [DATA_WIDTH-1:0] shifted;
    logic [DATA_WIDTH-1:0] load_data;

    assign offset    = req.addr[1:0];
    assign sram_addr = req.addr[BYTE_ADDR_WIDTH-1:2];

    // Halfwords need an even offset, words a zero one
    always_comb begin
        case (req.size)
            size_byte: misaligned = 1'b0;
            size_half: misaligned = offset[0];
            size_word: misaligned = offset != 2'b00;
            // Undefined size code is refused
            default:   misaligned = 1'b1;
        endcase
    end

    // Store data copied onto every lane it may land in
    // The mask then picks the lanes at the offset
    always_comb begin
        case (req.size)
            size_byte: begin
                sram_wdata = {4{req.wdata[7:0]}};
                sram_wmask = 4'b0001 << offset;
            end
            size_half: begin
                sram_wdata = {2{req.wdata[15:0]}};
                sram_wmask = 4'b0011 << offset;
            end
            default: begin
                sram_wdata = req.wdata;
                sram_wmask = 4'b1111;
            end
        endcase
    end

    // Only aligned stores reach the array
    assign sram_we = req_valid & req.write & ~misaligned;

    // Control flags of the response stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            err_q     <= 1'b0;
            load_q    <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
            err_q     <= req_valid & misaligned;
            load_q    <= req_valid & ~req.write;
        end
    end

    // Lane selection info for the next cycle
    always_ff @(posedge clk) begin
        offset_q   <= offset;
        size_q     <= req.size;
        unsigned_q <= req.is_unsigned;
    end

    // Addressed byte or halfword moved down to bit 0
    assign shifted = sram_rdata >> {offset_q, 3'b000};

    // Sign or zero extension by size
    always_comb begin
        case (size_q)
            size_byte: begin
                load_data = {{24{~unsigned_q & shifted[7]}}, shifted[7:0]};
            end
            size_half: begin
                load_data = {{16{~unsigned_q & shifted[15]}}, shifted[15:0]};
            end
            // Whole word with the extension mode ignored
            default: begin
                load_data = sram_rdata;
            end
        endcase
    end

    // Stores and errors return zero data
    assign rsp.err  = err_q;
    assign rsp.data = (load_q & ~err_q) ? load_data : '0;

endmodule

// File: hdl/fetch_port.sv
// Instruction fetch adapter with alignment check, word indexing and response register
`timescale 1ns/100ps

module fetch_port
    import mem_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    // Request side from the core
    input  logic                       req_valid,
    input  fetch_req_t                 req,
    // SRAM port 0
    output logic [WORD_ADDR_WIDTH-1:0] sram_addr,
    input  logic [DATA_WIDTH-1:0]      sram_rdata,
    // Response side one cycle after the request
    output logic                       rsp_valid,
    output fetch_rsp_t                 rsp
);

    logic misaligned;
    logic err_q;

    // Any nonzero byte offset is a misaligned fetch
    assign misaligned = req.addr[1:0] != 2'b00;

    // Word index drops the byte offset
    assign sram_addr = req.addr[BYTE_ADDR_WIDTH-1:2];

    // Response stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
            err_q     <= req_valid & misaligned;
        end
    end

    // SRAM word arrives in step with the registered flags
    // Error responses carry zero data
    assign rsp.err  = err_q;
    assign rsp.data = err_q ? '0 : sram_rdata;

endmodule

// File: hdl/dual_port_sram.sv
// True dual-port synchronous SRAM with byte write masks and registered read-before-write data
`timescale 1ns/100ps

module dual_port_sram #(
    parameter int DEPTH = 4096,
    parameter int DATA_WIDTH = 32,
    // Derived geometry
    localparam int ADDR_WIDTH = $clog2(DEPTH),
    localparam int WMASK_WIDTH = DATA_WIDTH / 8
) (
    input  logic                              clk,
    // Everything below is duplicated per port
    input  logic [1:0][ADDR_WIDTH-1:0]        addr,
    input  logic [1:0]                        we,
    input  logic [1:0][WMASK_WIDTH-1:0]       wmask,
    input  logic [1:0][DATA_WIDTH-1:0]        wdata,
    output logic [1:0][DATA_WIDTH-1:0]        rdata
);

    // Storage array shared by both ports
    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // Read stage
    // Nonblocking read samples the word before any write of this edge
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            rdata[p] <= mem[addr[p]];
        end
    end

    // Write stage
    // Both ports update the one array from a single process
    // Port 1 is applied last, so it wins a same-word write
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (we[p]) begin
                for (int b = 0; b < WMASK_WIDTH; b++) begin
                    // Only masked lanes change
                    if (wmask[p][b]) begin
                        mem[addr[p]][b*8 +: 8] <= wdata[p][b*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: hdl/mem_pkg.sv
// Memory geometry localparams, access size enumeration, fetch and data request/response structs
package mem_pkg;

    // Memory geometry
    localparam int MEM_WORDS = 4096;
    localparam int WORD_ADDR_WIDTH = $clog2(MEM_WORDS);
    // Byte address adds the two offset bits
    localparam int BYTE_ADDR_WIDTH = WORD_ADDR_WIDTH + 2;
    localparam int DATA_WIDTH = 32;
    // One mask bit per byte lane
    localparam int WMASK_WIDTH = DATA_WIDTH / 8;

    // Access size of a load or store
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

    // Instruction fetch request for a whole word
    typedef struct packed {
        logic [BYTE_ADDR_WIDTH-1:0] addr;
    } fetch_req_t;

    // Fetched word and misalignment flag
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  err;
    } fetch_rsp_t;

    // Load/store request
    typedef struct packed {
        logic [BYTE_ADDR_WIDTH-1:0] addr;
        // 1 for store, 0 for load
        logic                       write;
        mem_size_e                  size;
        // Zero extension on loads
        logic                       is_unsigned;
        // Store data sits in the low bits
        logic [DATA_WIDTH-1:0]      wdata;
    } data_req_t;

    // Extended load result that reads zero for stores and errors
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  err;
    } data_rsp_t;

endpackage
